//--- Bender.yml
package:
  name: memory_system

sources:
  - rtl/procPkg.sv
  - rtl/CacheStore.sv
  - rtl/DataMemory.sv
  - rtl/CacheController.sv
  - rtl/PeripheralBlock.sv
  - rtl/SegmentScanner.sv
  - rtl/MemorySystemTop.sv
  - target: test
    files:
      - dv/tbMemorySystem.sv

//--- compile.f
rtl/procPkg.sv
rtl/CacheStore.sv
rtl/DataMemory.sv
rtl/CacheController.sv
rtl/PeripheralBlock.sv
rtl/SegmentScanner.sv
rtl/MemorySystemTop.sv
dv/tbMemorySystem.sv

//--- dv/tbMemorySystem.sv
`timescale 1ns/1ps

module tbMemorySystem;
    import procPkg::*;

    localparam int cacheIndexBits = 4;
    localparam int memDepthLog    = 10;
    localparam int memLatency     = 3;
    localparam int scanDivider    = 8;
    localparam int randomOps      = 40;
    localparam int opCount        = randomOps + 20;
    localparam int cycleLimit     = opCount * (memLatency + 4) + 2 * 8 * scanDivider + 110;

    // Active-high segments gfedcba for hex digits 0 to F
    localparam logic [0:15][6:0] segLit = {
        7'h3F, 7'h06, 7'h5B, 7'h4F, 7'h66, 7'h6D, 7'h7D, 7'h07,
        7'h7F, 7'h6F, 7'h77, 7'h7C, 7'h39, 7'h5E, 7'h79, 7'h71};

    typedef struct packed {
        logic        known;    // Word was written since reset
        logic [31:0] data;
        logic [7:0]  latency;
    } expReadT;

    logic        CLK;
    logic        reset;
    logic        cacheValid;
    cpuReqT      cacheReq;
    logic        cacheReadReady;
    logic [31:0] cacheReadData;
    logic [31:0] ioAddr;
    logic [31:0] ioWriteData;
    logic        ioWE;
    logic [31:0] ioReadData;
    logic [15:0] sw;
    logic [15:0] led;
    logic [7:0]  sevenSegAn;
    logic [6:0]  sevenSegCat;

    logic [31:0]                shadowMem [1 << memDepthLog];
    bit                         shadowKnown [1 << memDepthLog];
    bit                         refValid [1 << cacheIndexBits];
    logic [29-cacheIndexBits:0] refTag [1 << cacheIndexBits];
    expReadT                    expQ [$];
    int                         seed = 32'h2212;
    int                         errorCount;
    int                         checkCount;
    int                         testStartErrors;
    int                         cycleCount;
    int                         scanCycles;    // Clock edges since reset released
    int                         readWait;

    MemorySystemTop #(
        .cacheIndexBits(cacheIndexBits),
        .memDepthLog   (memDepthLog   ),
        .memLatency    (memLatency    ),
        .scanDivider   (scanDivider   )
    ) UUT (
        .CLK(CLK), .reset(reset),
        .cacheValid(cacheValid), .cacheReq(cacheReq),
        .cacheReadReady(cacheReadReady), .cacheReadData(cacheReadData),
        .ioAddr(ioAddr), .ioWriteData(ioWriteData), .ioWE(ioWE), .ioReadData(ioReadData),
        .sw(sw), .led(led), .sevenSegAn(sevenSegAn), .sevenSegCat(sevenSegCat));

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    always @(posedge CLK) begin
        cycleCount = cycleCount + 1;
        if (!reset) begin
            scanCycles = scanCycles + 1;
        end
        if (cycleCount > cycleLimit) begin
            $display("Timeout: run stopped after %0d cycles without finishing", cycleCount);
            $display("test failed");
            $finish;
        end
    end

    // Hit while the tracked line matches, else the miss path
    function automatic expReadT expectRead(input logic [31:0] addr);
        expReadT exp;
        int      idx;
        int      word;
        idx         = addr[cacheIndexBits+1:2];
        word        = addr[memDepthLog+1:2];
        exp.known   = shadowKnown[word];
        exp.data    = shadowMem[word];
        exp.latency = (refValid[idx] && refTag[idx] == addr[31:cacheIndexBits+2])
                      ? 8'd1 : 8'(memLatency + 2);
        return exp;
    endfunction

    function automatic logic [6:0] segExpect(input logic [3:0] hex);
        return ~segLit[hex];
    endfunction

    task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] want);
        checkCount++;
        assert (got === want) else begin
            errorCount++;
            $display("FAIL %s: expected %h, got %h", name, want, got);
        end
    endtask

    task automatic finishTest(input string name);
        $display("%-18s %0d errors", name, errorCount - testStartErrors);
        testStartErrors = errorCount;
    endtask

    task automatic cacheRead(input logic [31:0] addr);
        int idx;
        idx = addr[cacheIndexBits+1:2];
        expQ.push_back(expectRead(addr));
        refValid[idx] = 1'b1;                    // Line holds this address afterwards
        refTag[idx]   = addr[31:cacheIndexBits+2];
        @(posedge CLK);
        #1;
        cacheValid    = 1'b1;
        cacheReq.rw   = 1'b0;
        cacheReq.addr = addr;
        do @(negedge CLK); while (!cacheReadReady);
        @(posedge CLK);
        #1;
        cacheValid = 1'b0;
    endtask

    task automatic cacheWrite(input logic [31:0] addr, input logic [31:0] data);
        @(posedge CLK);
        #1;
        cacheValid         = 1'b1;
        cacheReq.rw        = 1'b1;
        cacheReq.addr      = addr;
        cacheReq.writeData = data;
        shadowMem[addr[memDepthLog+1:2]]   = data;
        shadowKnown[addr[memDepthLog+1:2]] = 1'b1;
        @(posedge CLK);
        #1;
        cacheValid = 1'b0;
    endtask

    task automatic ioWrite(input logic [31:0] addr, input logic [31:0] data);
        @(posedge CLK);
        #1;
        ioAddr      = addr;
        ioWriteData = data;
        ioWE        = 1'b1;
        @(posedge CLK);
        #1;
        ioWE = 1'b0;
    endtask

    task automatic ioCheck(input logic [31:0] addr, input logic [31:0] want);
        @(posedge CLK);
        #1;
        ioAddr = addr;
        @(negedge CLK);
        checkValue("ioReadData", ioReadData, want);
    endtask

    task automatic checkScan(input logic [31:0] value);
        int         digit;
        logic [7:0] anExpect;
        ioWrite(segAddr, value);
        repeat (8 * scanDivider) begin
            @(negedge CLK);
            digit           = (scanCycles / scanDivider) % 8;
            anExpect        = 8'hFF;
            anExpect[digit] = 1'b0;              // Only the scanned digit is driven
            checkValue("sevenSegAn", 32'(sevenSegAn), 32'(anExpect));
            checkValue("sevenSegCat", 32'(sevenSegCat), 32'(segExpect(value[digit*4 +: 4])));
        end
    endtask

    // Measures each read response against the queued expectation
    always @(negedge CLK) begin : compareResponse
        expReadT exp;
        assert (!cacheReadReady || (cacheValid && !cacheReq.rw)) else begin
            errorCount++;
            $display("cacheReadReady went high with no read outstanding");
        end
        if (!reset && cacheValid && !cacheReq.rw) begin
            readWait = readWait + 1;
            if (cacheReadReady) begin
                exp = expQ.pop_front();
                checkCount++;
                assert (readWait - 1 == exp.latency) else begin
                    errorCount++;
                    $display("Read of %h answered after %0d cycles instead of %0d",
                             cacheReq.addr, readWait - 1, exp.latency);
                end
                if (exp.known) begin
                    checkValue("cacheReadData", cacheReadData, exp.data);
                end
                readWait = 0;
            end
        end
    end

    initial begin : mainSequence
        logic [31:0] addr;
        logic [31:0] data;
        reset       = 1'b1;
        cacheValid  = 1'b0;
        cacheReq    = '0;
        ioAddr      = '0;
        ioWriteData = '0;
        ioWE        = 1'b0;
        sw          = '0;
        repeat (10) @(posedge CLK);
        #1;
        reset = 1'b0;
        @(negedge CLK);
        checkValue("led", 32'(led), 32'h0);
        checkValue("cacheReadReady", 32'(cacheReadReady), 32'h0);
        checkValue("sevenSegAn", 32'(sevenSegAn), 32'hFE);
        cacheRead(32'h0000_0200);                 // Cold miss with unknown contents
        finishTest("reset state");

        data = $random(seed);
        cacheWrite(32'h0000_0300, data);
        cacheRead(32'h0000_0300);
        cacheRead(32'h0000_0300);
        finishTest("read after write");

        data = $random(seed);
        cacheWrite(32'h0000_0300, data);
        cacheRead(32'h0000_0300);
        cacheRead(32'h0000_0340);                 // Evicts the line at the same index
        cacheRead(32'h0000_0300);                 // Refilled from memory
        finishTest("write-through");

        repeat (randomOps) begin
            addr = 32'h400 + (($random(seed) & 3) << 6) + (($random(seed) & 1) << 2);
            if ($random(seed) & 1) begin
                cacheWrite(addr, $random(seed));
            end else begin
                cacheRead(addr);
            end
        end
        finishTest("eviction");

        data = $random(seed);
        ioWrite(ledAddr, data);
        checkValue("led", 32'(led), {16'h0000, data[15:0]});
        ioCheck(ledAddr, {16'h0000, data[15:0]});
        data = $random(seed);
        sw   = data[15:0];
        ioCheck(swAddr, {16'h0000, data[15:0]});
        data = $random(seed);
        ioWrite(segAddr, data);
        ioCheck(segAddr, data);
        ioCheck(32'hFFFF_FC90, 32'h0);
        ioCheck(32'h0000_0060, 32'h0);
        finishTest("io registers");

        checkScan(32'h89AB_CDEF);
        checkScan(32'h0123_4567);
        finishTest("segment scan");

        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- rtl/CacheController.sv
`timescale 1ns/1ps

module CacheController (
    input  logic              CLK,
    input  logic              reset,
    input  logic              cacheValid,
    input  procPkg::cpuReqT   cacheReq,
    output logic              cacheReadReady,
    output logic [31:0]       cacheReadData,
    input  logic              hit,
    input  logic [31:0]       hitData,
    output logic              lineWrite,
    output logic [31:0]       lineData,
    output logic              memReadValid,
    output logic [31:0]       memReadAddr,
    input  logic              memReadReady,
    input  logic [31:0]       memReadData,
    output logic              memWriteValid,
    output procPkg::memWriteT memWrite
);
    import procPkg::*;

    cacheStateT  state;
    logic [31:0] reqAddr;      // Address of the read being served
    logic [31:0] readDataReg;
    logic        readAccept;
    logic        writeAccept;

    assign readAccept  = (state == Idle) && cacheValid && !cacheReq.rw;
    assign writeAccept = (state == Idle) && cacheValid && cacheReq.rw;

    // Store and memory share this address; live request while Idle
    assign memReadAddr = (state == Idle) ? cacheReq.addr : reqAddr;

    assign memReadValid   = (state == MissWait);
    assign cacheReadReady = (state == Respond);
    assign cacheReadData  = readDataReg;

    // Fill on memory return, or update a hit line on write-through
    assign lineWrite = (writeAccept && hit) || ((state == MissWait) && memReadReady);
    assign lineData  = (state == MissWait) ? memReadData : cacheReq.writeData;

    always_ff @(posedge CLK) begin
        if (reset) begin
            state         <= Idle;
            memWriteValid <= 1'b0;
        end else begin
            memWriteValid <= writeAccept;  // Strobe one cycle after accept
            case (state)
                Idle: begin
                    if (readAccept) begin
                        state <= hit ? Respond : MissWait;
                    end
                end
                MissWait: begin
                    if (memReadReady) begin
                        state <= Respond;
                    end
                end
                Respond: state <= Idle;    // Core drops the request here
                default: state <= Idle;
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (readAccept) begin
            reqAddr     <= cacheReq.addr;
            readDataReg <= hitData;
        end else if ((state == MissWait) && memReadReady) begin
            readDataReg <= memReadData;
        end
        if (writeAccept) begin
            memWrite.addr <= cacheReq.addr;
            memWrite.data <= cacheReq.writeData;
        end
    end

    // Memory read request is a held level
    assert property (@(posedge CLK) disable iff (reset)
        memReadValid && !memReadReady |=> memReadValid);

    // Read response is always a single-cycle pulse
    assert property (@(posedge CLK) disable iff (reset)
        cacheReadReady |=> !cacheReadReady);

endmodule

//--- rtl/CacheStore.sv
`timescale 1ns/1ps

module CacheStore #(
    parameter int cacheIndexBits = 4
) (
    input  logic        CLK,
    input  logic        reset,
    input  logic [31:0] addr,
    output logic        hit,
    output logic [31:0] hitData,
    input  logic        lineWrite,
    input  logic [31:0] lineData
);
    localparam int tagBits   = 30 - cacheIndexBits;
    localparam int lineCount = 1 << cacheIndexBits;

    typedef struct packed {
        logic               valid;
        logic [tagBits-1:0] tag;
        logic [31:0]        data;
    } cacheLineT;

    cacheLineT                 lines [lineCount];
    cacheLineT                 curLine;
    logic [cacheIndexBits-1:0] index;
    logic [tagBits-1:0]        tag;

    // Word address split, byte offset ignored
    assign index = addr[cacheIndexBits+1:2];
    assign tag   = addr[31:cacheIndexBits+2];

    assign curLine = lines[index];
    assign hit     = curLine.valid && (curLine.tag == tag);
    assign hitData = curLine.data;

    always_ff @(posedge CLK) begin
        if (reset) begin
            for (int i = 0; i < lineCount; i++) begin
                lines[i].valid <= 1'b0;  // Tag and data keep their contents
            end
        end else if (lineWrite) begin
            lines[index].valid <= 1'b1;
            lines[index].tag   <= tag;
            lines[index].data  <= lineData;
        end
    end

endmodule

//--- rtl/DataMemory.sv
`timescale 1ns/1ps

module DataMemory #(
    parameter int memDepthLog = 10,
    parameter int memLatency  = 3
) (
    input  logic              CLK,
    input  logic              reset,
    input  logic              readValid,
    input  logic [31:0]       readAddr,
    output logic              readReady,
    output logic [31:0]       readData,
    input  logic              writeValid,
    input  procPkg::memWriteT write
);
    localparam int cntBits = $clog2(memLatency + 1);

    logic [31:0]        mem [1 << memDepthLog];
    logic [cntBits-1:0] latencyCount;
    logic               lastWait;

    // Final wait cycle before the data is returned
    assign lastWait = (latencyCount == cntBits'(memLatency - 1));

    always_ff @(posedge CLK) begin
        if (writeValid) begin
            mem[write.addr[memDepthLog+1:2]] <= write.data;
        end
    end

    always_ff @(posedge CLK) begin
        if (reset) begin
            readReady    <= 1'b0;
            latencyCount <= '0;
        end else if (readValid && !readReady) begin
            readReady    <= lastWait;
            latencyCount <= lastWait ? '0 : latencyCount + 1'b1;
        end else begin
            readReady    <= 1'b0;        // Pulse lasts one cycle
            latencyCount <= '0;
        end
    end

    always_ff @(posedge CLK) begin
        if (readValid && !readReady && lastWait) begin
            readData <= mem[readAddr[memDepthLog+1:2]];
        end
    end

    // The requester holds the read until the data comes back
    assert property (@(posedge CLK) disable iff (reset)
        $fell(readValid) |-> $past(readReady));

endmodule

//--- rtl/MemorySystemTop.sv
`timescale 1ns/1ps

module MemorySystemTop #(
    parameter int cacheIndexBits = 4,
    parameter int memDepthLog    = 10,
    parameter int memLatency     = 3,
    parameter int scanDivider    = 8
) (
    input  logic            CLK,
    input  logic            reset,
    input  logic            cacheValid,
    input  procPkg::cpuReqT cacheReq,
    output logic            cacheReadReady,
    output logic [31:0]     cacheReadData,
    input  logic [31:0]     ioAddr,
    input  logic [31:0]     ioWriteData,
    input  logic            ioWE,
    output logic [31:0]     ioReadData,
    input  logic [15:0]     sw,
    output logic [15:0]     led,
    output logic [7:0]      sevenSegAn,
    output logic [6:0]      sevenSegCat
);
    import procPkg::*;

    logic        hit;
    logic [31:0] hitData;
    logic        lineWrite;
    logic [31:0] lineData;
    logic        memReadValid;
    logic [31:0] memReadAddr;      // Also indexes the cache store
    logic        memReadReady;
    logic [31:0] memReadData;
    logic        memWriteValid;
    memWriteT    memWrite;
    logic [31:0] segValue;

    CacheController CacheController (
        .CLK           (CLK           ),
        .reset         (reset         ),
        .cacheValid    (cacheValid    ),
        .cacheReq      (cacheReq      ),
        .cacheReadReady(cacheReadReady),
        .cacheReadData (cacheReadData ),
        .hit           (hit           ),
        .hitData       (hitData       ),
        .lineWrite     (lineWrite     ),
        .lineData      (lineData      ),
        .memReadValid  (memReadValid  ),
        .memReadAddr   (memReadAddr   ),
        .memReadReady  (memReadReady  ),
        .memReadData   (memReadData   ),
        .memWriteValid (memWriteValid ),
        .memWrite      (memWrite      ));

    CacheStore #(.cacheIndexBits(cacheIndexBits)) CacheStore (
        .CLK      (CLK        ),
        .reset    (reset      ),
        .addr     (memReadAddr),
        .hit      (hit        ),
        .hitData  (hitData    ),
        .lineWrite(lineWrite  ),
        .lineData (lineData   ));

    DataMemory #(
        .memDepthLog(memDepthLog),
        .memLatency (memLatency )
    ) DataMemory (
        .CLK       (CLK          ),
        .reset     (reset        ),
        .readValid (memReadValid ),
        .readAddr  (memReadAddr  ),
        .readReady (memReadReady ),
        .readData  (memReadData  ),
        .writeValid(memWriteValid),
        .write     (memWrite     ));

    PeripheralBlock PeripheralBlock (
        .CLK        (CLK        ),
        .reset      (reset      ),
        .ioAddr     (ioAddr     ),
        .ioWriteData(ioWriteData),
        .ioWE       (ioWE       ),
        .ioReadData (ioReadData ),
        .sw         (sw         ),
        .led        (led        ),
        .segValue   (segValue   ));

    SegmentScanner #(.scanDivider(scanDivider)) SegmentScanner (
        .CLK        (CLK        ),
        .reset      (reset      ),
        .segValue   (segValue   ),
        .sevenSegAn (sevenSegAn ),
        .sevenSegCat(sevenSegCat));

endmodule

//--- rtl/PeripheralBlock.sv
`timescale 1ns/1ps

module PeripheralBlock (
    input  logic        CLK,
    input  logic        reset,
    input  logic [31:0] ioAddr,
    input  logic [31:0] ioWriteData,
    input  logic        ioWE,
    output logic [31:0] ioReadData,
    input  logic [15:0] sw,
    output logic [15:0] led,
    output logic [31:0] segValue
);
    import procPkg::*;

    logic        ioRegion;
    logic        ledSel;
    logic        swSel;
    logic        segSel;
    logic [15:0] ledReg;
    logic [31:0] segReg;

    // Upper bits pick the I/O page, low ten bits pick the register
    assign ioRegion = (ioAddr[31:10] == ioBase[31:10]);
    assign ledSel   = ioRegion && (ioAddr[9:0] == ledAddr[9:0]);
    assign swSel    = ioRegion && (ioAddr[9:0] == swAddr[9:0]);
    assign segSel   = ioRegion && (ioAddr[9:0] == segAddr[9:0]);

    always_ff @(posedge CLK) begin
        if (reset) begin
            ledReg <= '0;
            segReg <= '0;
        end else if (ioWE) begin
            if (ledSel) begin
                ledReg <= ioWriteData[15:0];
            end
            if (segSel) begin
                segReg <= ioWriteData;
            end
        end
    end

    always_comb begin
        ioReadData = '0;               // Unmapped addresses read zero
        if (ledSel) begin
            ioReadData = {16'h0000, ledReg};
        end else if (swSel) begin
            ioReadData = {16'h0000, sw};
        end else if (segSel) begin
            ioReadData = segReg;
        end
    end

    assign led      = ledReg;
    assign segValue = segReg;

endmodule

//--- rtl/SegmentScanner.sv
`timescale 1ns/1ps

module SegmentScanner #(
    parameter int scanDivider = 8
) (
    input  logic        CLK,
    input  logic        reset,
    input  logic [31:0] segValue,
    output logic [7:0]  sevenSegAn,
    output logic [6:0]  sevenSegCat
);
    import procPkg::*;

    localparam int divBits = $clog2(scanDivider + 1);

    logic [divBits-1:0] divCount;
    logic [2:0]         digit;
    logic [3:0]         nibble;

    always_ff @(posedge CLK) begin
        if (reset) begin
            divCount <= '0;
            digit    <= '0;
        end else if (divCount == divBits'(scanDivider - 1)) begin
            divCount <= '0;
            digit    <= digit + 1'b1;  // Wraps after digit 7
        end else begin
            divCount <= divCount + 1'b1;
        end
    end

    assign nibble      = segValue[digit*4 +: 4];
    assign sevenSegAn  = ~(8'b0000_0001 << digit);
    assign sevenSegCat = segPattern(nibble);

    // One digit lit at a time
    assert property (@(posedge CLK) disable iff (reset) $onehot(~sevenSegAn));

endmodule

//--- rtl/procPkg.sv
package procPkg;

    // Memory-mapped I/O region and register addresses
    localparam logic [31:0] ioBase  = 32'hFFFF_FC00;
    localparam logic [31:0] ledAddr = 32'hFFFF_FC60;
    localparam logic [31:0] swAddr  = 32'hFFFF_FC70;
    localparam logic [31:0] segAddr = 32'hFFFF_FC80;

    typedef struct packed {
        logic        rw;        // 1 is a write
        logic [31:0] addr;
        logic [31:0] writeData;
    } cpuReqT;

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] data;
    } memWriteT;

    typedef enum logic [1:0] {
        Idle,
        MissWait,
        Respond
    } cacheStateT;

    // Active-low cathodes with segment a in bit 0 and segment g in bit 6
    function automatic logic [6:0] segPattern(input logic [3:0] digit);
        logic [6:0] pattern;
        case (digit)
            4'h0: pattern = 7'h40;
            4'h1: pattern = 7'h79;
            4'h2: pattern = 7'h24;
            4'h3: pattern = 7'h30;
            4'h4: pattern = 7'h19;
            4'h5: pattern = 7'h12;
            4'h6: pattern = 7'h02;
            4'h7: pattern = 7'h78;
            4'h8: pattern = 7'h00;
            4'h9: pattern = 7'h10;
            4'hA: pattern = 7'h08;
            4'hB: pattern = 7'h03;
            4'hC: pattern = 7'h46;
            4'hD: pattern = 7'h21;
            4'hE: pattern = 7'h06;
            default: pattern = 7'h0E;
        endcase
        return pattern;
    endfunction

endpackage
